/* Makefile */
TOP = displayBench

# Build with Verilator and run, pass only on a clean report
sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* bench/displayBench.sv */
`timescale 1ns/10ps
`include "display_macros.svh"

module displayBench
    import displayPkg::*;
    import controlPkg::*;
();

    // Reset, scan order, eight speed codes, eight offset codes, burst
    localparam int NUM_TESTS   = 19;
    localparam int WATCHDOG_NS = NUM_TESTS * 4 * 8 * `SCAN_DIV * 8 + 4 * 8;
    // Speed readout in hundredths, indexed by code
    localparam int SPEED_HUNDREDTHS [8] = '{100, 25, 50, 100, 125, 150, 200, 300};

    logic       O_CLK = 1'b0;
    logic       rstN;
    settingsT   settings;
    logic       setValid;
    segmentT    seg;
    anodeT      an;

    string      testName = "reset";
    int         edgesSinceReset = 0;
    int         periodLen = 0;
    int         periodsSeen = 0;
    int         frameCount = 0;
    logic [2:0] scanPos = 3'd7;
    anodeT      prevAn = '1;
    segmentT    digitSegs [8] = '{default: '1};
    frameT      lastFrame;
    logic       burstCheck = 1'b0;
    settingsT   applied [$];
    integer     seed = 38;

    displayTop UUT (
        .O_CLK    (O_CLK),
        .rstN     (rstN),
        .settings (settings),
        .setValid (setValid),
        .seg      (seg),
        .an       (an)
    );

    always #4 O_CLK = ~O_CLK;

    // ************************************************************************
    // Reference model
    // ************************************************************************

    function automatic frameT expectFrame(input settingsT s);
        digitT d [8];
        int    hundredths;
        int    mag;
        for (int i = 0; i < 8; i++) begin
            d[i] = '{glyph: glyphBlank, point: 1'b0};
        end
        // x.yz with the point on digit 2
        hundredths = SPEED_HUNDREDTHS[s.speed];
        d[2] = '{glyph: glyphT'(4'(hundredths / 100)), point: 1'b1};
        d[1].glyph = glyphT'(4'((hundredths / 10) % 10));
        d[0].glyph = glyphT'(4'(hundredths % 10));
        // Codes 1..3 count down on the minus side, 5..7 count up
        mag = 0;
        if (s.freq >= 3'd1 && s.freq <= 3'd3) begin
            d[7].glyph = glyphMinus;
            mag = 4 - int'(s.freq);
        end
        else if (s.freq >= 3'd5) begin
            d[7].glyph = glyphPlus;
            mag = int'(s.freq) - 4;
        end
        d[6].glyph = glyphT'(4'(mag));
        return {d[7], d[6], d[5], d[4], d[3], d[2], d[1], d[0]};
    endfunction

    // Lit segments listed gfedcba active high, then turned into pin levels
    function automatic segmentT glyphSegments(input glyphT g);
        logic [6:0] lit;
        case (g)
            glyph0:     lit = 7'b0111111;
            glyph1:     lit = 7'b0000110;
            glyph2:     lit = 7'b1011011;
            glyph3:     lit = 7'b1001111;
            glyph4:     lit = 7'b1100110;
            glyph5:     lit = 7'b1101101;
            glyph6:     lit = 7'b1111101;
            glyph7:     lit = 7'b0000111;
            glyph8:     lit = 7'b1111111;
            glyph9:     lit = 7'b1101111;
            glyphMinus: lit = 7'b0111000;  // L
            glyphPlus:  lit = 7'b1110110;  // H
            default:    lit = 7'b0000000;
        endcase
        return {~lit, 1'b1};
    endfunction

    // Unknown patterns decode to code 15 so they never match
    function automatic digitT decodeDigit(input segmentT s);
        digitT   d;
        segmentT pattern;
        d = '{glyph: glyphT'(4'hF), point: ~s[0]};
        for (int g = 0; g < 13; g++) begin
            pattern = glyphSegments(glyphT'(4'(g)));
            if (pattern[7:1] == s[7:1]) begin
                d.glyph = glyphT'(4'(g));
            end
        end
        return d;
    endfunction

    function automatic logic isAppliedFrame(input frameT f);
        foreach (applied[i]) begin
            if (expectFrame(applied[i]) == f) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // ************************************************************************
    // Compare tasks
    // ************************************************************************

    task automatic stopRun();
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkSegment(input string name, input segmentT expected, input segmentT actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkAnode(input string name, input anodeT expected, input anodeT actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkFrame(input string name, input frameT expected, input frameT actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkPeriod(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
            stopRun();
        end
    endtask

    // ************************************************************************
    // Capture and compare
    // ************************************************************************

    always @(posedge O_CLK) begin
        if (!rstN) begin
            edgesSinceReset <= 0;
        end
        else begin
            edgesSinceReset <= edgesSinceReset + 1;
        end
    end

    // Sampled mid-cycle, well away from the registered outputs
    always @(negedge O_CLK) begin
        if (!rstN || edgesSinceReset < `SCAN_DIV) begin
            checkAnode("reset", '1, an);
            checkSegment("reset", '1, seg);
        end
        else if (an != prevAn) begin
            if (periodsSeen > 0) begin
                checkPeriod("scan order", `SCAN_DIV, periodLen);
            end
            scanPos = scanPos + 3'd1;
            checkAnode("scan order", ~(8'b1 << scanPos), an);
            // Wrap to digit 0 closes a full frame
            if (scanPos == 3'd0 && periodsSeen >= 8) begin
                lastFrame = {decodeDigit(digitSegs[7]), decodeDigit(digitSegs[6]),
                             decodeDigit(digitSegs[5]), decodeDigit(digitSegs[4]),
                             decodeDigit(digitSegs[3]), decodeDigit(digitSegs[2]),
                             decodeDigit(digitSegs[1]), decodeDigit(digitSegs[0])};
                if (burstCheck && !isAppliedFrame(lastFrame)) begin
                    $display("Fail %s: frame %h matches none of the applied settings",
                             testName, lastFrame);
                    stopRun();
                end
                frameCount++;
            end
            digitSegs[scanPos] = seg;
            prevAn = an;
            periodLen = 1;
            periodsSeen++;
        end
        else begin
            // Segments must hold for the whole digit period
            checkSegment("segment hold", digitSegs[scanPos], seg);
            periodLen++;
            if (periodLen > `SCAN_DIV) begin
                checkPeriod("scan order", `SCAN_DIV, periodLen);
            end
        end
    end

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    // Applied just after a frame starts, so the next frame is the new one
    task automatic showSetting(input settingsT s);
        int startCount;
        startCount = frameCount + 1;
        wait (frameCount >= startCount);
        @(posedge O_CLK);
        #1;
        settings = s;
        setValid = 1'b1;
        @(posedge O_CLK);
        #1;
        setValid = 1'b0;
        wait (frameCount >= startCount + 2);
        checkFrame(testName, expectFrame(s), lastFrame);
    endtask

    initial begin
        frameT       idleFrame;
        settingsT    s;
        logic [31:0] rnd;
        int          burstEnd;
        rstN = 1'b0;
        settings = '0;
        setValid = 1'b0;
        idleFrame = {8{glyphBlank, 1'b0}};
        repeat (4) @(posedge O_CLK);
        #1;
        rstN = 1'b1;

        // Nothing adopted yet
        testName = "scan order";
        wait (frameCount >= 2);
        checkFrame(testName, idleFrame, lastFrame);

        for (int i = 0; i < 8; i++) begin
            testName = $sformatf("speed code %0d", i);
            s.speed = 3'(i);
            s.freq = 3'd0;
            showSetting(s);
        end
        for (int i = 0; i < 8; i++) begin
            testName = $sformatf("frequency code %0d", i);
            s.speed = 3'd5;
            s.freq = 3'(i);
            showSetting(s);
        end

        // Burst on back-to-back cycles, the last offset setting may still show
        testName = "back-pressure";
        applied.push_back(s);
        burstCheck = 1'b1;
        for (int i = 0; i < 40; i++) begin
            @(posedge O_CLK);
            #1;
            rnd = $random(seed);
            s = settingsT'(rnd[5:0]);
            settings = s;
            setValid = 1'b1;
            applied.push_back(s);
        end
        @(posedge O_CLK);
        #1;
        setValid = 1'b0;
        burstEnd = frameCount;
        wait (frameCount >= burstEnd + `FRAME_CREDITS + 2);
        checkFrame(testName, expectFrame(s), lastFrame);

        $display("No errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
        stopRun();
    end

endmodule

/* build.f */
+incdir+include
verilog/displayPkg.sv
verilog/controlPkg.sv
verilog/segmentEncoder.sv
verilog/settingsFormatter.sv
verilog/scanDriver.sv
verilog/displayTop.sv
bench/displayBench.sv

/* include/display_macros.svh */
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// ************************************************************************
// Front-panel display build parameters
// ************************************************************************

// O_CLK cycles that each digit stays lit
// Kept small for simulation, a board build uses something like 5000
`define SCAN_DIV 4

// Depth of the frame queue in the scan driver
// Also the number of credits the formatter holds after reset
`define FRAME_CREDITS 2

`endif

/* verilog/controlPkg.sv */
package controlPkg;

    // ************************************************************************
    // Drive controller side
    // ************************************************************************

    // Codes as sent by the controller
    // speed selects 0.25 to 3.00, freq is a signed offset
    typedef struct packed {
        logic [2:0] speed;
        logic [2:0] freq;
    } settingsT;

    // Formatter FSM
    // fmtSend is the single cycle in which frameValid is up
    typedef enum logic {
        fmtIdle = 1'b0,
        fmtSend = 1'b1
    } fmtStateT;

endpackage

/* verilog/displayPkg.sv */
package displayPkg;

    // Glyphs the panel can show
    // Codes 13 to 15 are unused and come out dark
    typedef enum logic [3:0] {
        glyph0     = 4'd0,
        glyph1     = 4'd1,
        glyph2     = 4'd2,
        glyph3     = 4'd3,
        glyph4     = 4'd4,
        glyph5     = 4'd5,
        glyph6     = 4'd6,
        glyph7     = 4'd7,
        glyph8     = 4'd8,
        glyph9     = 4'd9,
        glyphMinus = 4'd10,
        glyphPlus  = 4'd11,
        glyphBlank = 4'd12
    } glyphT;

    // One character position, glyph plus decimal point
    typedef struct packed {
        glyphT glyph;
        logic  point;
    } digitT;

    // Whole panel, leftmost digit in the top bits
    typedef struct packed {
        digitT digit7;
        digitT digit6;
        digitT digit5;
        digitT digit4;
        digitT digit3;
        digitT digit2;
        digitT digit1;
        digitT digit0;
    } frameT;

    // Segments gfedcba then point, low lights the segment
    typedef logic [7:0] segmentT;

    // Common-anode enables, bit n low selects digit n
    typedef logic [7:0] anodeT;

    localparam digitT blankDigit = '{glyph: glyphBlank, point: 1'b0};
    localparam frameT blankFrame = '{blankDigit, blankDigit, blankDigit, blankDigit,
                                     blankDigit, blankDigit, blankDigit, blankDigit};

endpackage

/* verilog/displayTop.sv */
`timescale 1ns/10ps

module displayTop
    import displayPkg::*;
    import controlPkg::*;
(
    input  logic     O_CLK,
    input  logic     rstN,
    input  settingsT settings,
    input  logic     setValid,
    output segmentT  seg,
    output anodeT    an
);

    // Frame link between formatter and scan driver
    frameT frame;
    logic  frameValid;
    logic  creditReturn;

    settingsFormatter formatter (
        .O_CLK        (O_CLK),
        .rstN         (rstN),
        .settings     (settings),
        .setValid     (setValid),
        .frame        (frame),
        .frameValid   (frameValid),
        .creditReturn (creditReturn)
    );

    scanDriver driver (
        .O_CLK        (O_CLK),
        .rstN         (rstN),
        .frame        (frame),
        .frameValid   (frameValid),
        .creditReturn (creditReturn),
        .seg          (seg),
        .an           (an)
    );

endmodule

/* verilog/scanDriver.sv */
`timescale 1ns/10ps
`include "display_macros.svh"

module scanDriver
    import displayPkg::*;
(
    input  logic    O_CLK,
    input  logic    rstN,
    input  frameT   frame,
    input  logic    frameValid,
    output logic    creditReturn,
    output segmentT seg,
    output anodeT   an
);

    localparam int DEPTH = `FRAME_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int PRE_W = (`SCAN_DIV > 1) ? $clog2(`SCAN_DIV) : 1;

    frameT            queueMem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] queueCount;
    logic             queueEmpty;
    logic             queueFull;
    logic             pop;
    logic [PRE_W-1:0] prescale;
    logic             tick;
    logic [2:0]       position;
    logic [2:0]       nextPos;
    frameT            shownFrame;
    frameT            activeFrame;
    digitT            curDigit;
    segmentT          segNext;

    // ************************************************************************
    // Frame queue
    // ************************************************************************

    assign queueEmpty = (queueCount == '0);
    assign queueFull  = (queueCount == CNT_W'(DEPTH));

    // Storage, no reset needed
    always_ff @(posedge O_CLK) begin
        if (frameValid) begin
            queueMem[wrPtr] <= frame;
        end
    end

    // ************************************************************************
    // Scan timing and digit select
    // ************************************************************************

    assign tick    = (prescale == PRE_W'(`SCAN_DIV - 1));
    assign nextPos = position + 3'd1;

    // New frames are taken only when the scan wraps to digit 0
    assign pop         = tick && (nextPos == 3'd0) && !queueEmpty;
    assign activeFrame = pop ? queueMem[rdPtr] : shownFrame;

    always_comb begin
        unique case (nextPos)
            3'd0: curDigit = activeFrame.digit0;
            3'd1: curDigit = activeFrame.digit1;
            3'd2: curDigit = activeFrame.digit2;
            3'd3: curDigit = activeFrame.digit3;
            3'd4: curDigit = activeFrame.digit4;
            3'd5: curDigit = activeFrame.digit5;
            3'd6: curDigit = activeFrame.digit6;
            3'd7: curDigit = activeFrame.digit7;
        endcase
    end

    segmentEncoder encoder (
        .digit (curDigit),
        .seg   (segNext)
    );

    always_ff @(posedge O_CLK) begin
        if (!rstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            queueCount   <= '0;
            prescale     <= '0;
            // Starts at 7 so the first tick lands on digit 0
            position     <= 3'd7;
            shownFrame   <= blankFrame;
            creditReturn <= 1'b0;
            seg          <= '1;
            an           <= '1;
        end
        else begin
            creditReturn <= pop;
            queueCount   <= queueCount + CNT_W'(frameValid) - CNT_W'(pop);
            if (frameValid) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr      <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
                shownFrame <= queueMem[rdPtr];
            end
            prescale <= tick ? '0 : prescale + PRE_W'(1);
            if (tick) begin
                position <= nextPos;
                // Anode and segments switch on the same edge
                seg      <= segNext;
                an       <= ~(8'b1 << nextPos);
            end
        end
    end

    // Formatter credits must keep writes off a full queue
    assert property (@(posedge O_CLK) disable iff (!rstN)
        frameValid |-> !queueFull);

    // Each frame arrives as a single-cycle pulse
    // A held strobe would write the same frame twice
    assert property (@(posedge O_CLK) disable iff (!rstN)
        frameValid |=> !frameValid);

endmodule

/* verilog/segmentEncoder.sv */
`timescale 1ns/10ps

module segmentEncoder
    import displayPkg::*;
(
    input  digitT   digit,
    output segmentT seg
);

    // Pure lookup, registered by the caller
    always_comb begin
        // Patterns are gfedcba then point, active low
        unique case (digit.glyph)
            glyph0:     seg = 8'b10000001;
            glyph1:     seg = 8'b11110011;
            glyph2:     seg = 8'b01001001;
            glyph3:     seg = 8'b01100001;
            glyph4:     seg = 8'b00110011;
            glyph5:     seg = 8'b00100101;
            glyph6:     seg = 8'b00000101;
            glyph7:     seg = 8'b11110001;
            glyph8:     seg = 8'b00000001;
            glyph9:     seg = 8'b00100001;
            // L shape stands for the minus sign
            glyphMinus: seg = 8'b10001111;
            // H shape stands for the plus sign
            glyphPlus:  seg = 8'b00010011;
            // Blank and the spare codes stay dark
            default:    seg = 8'b11111111;
        endcase

        // Decimal point sits in bit 0
        if (digit.point) begin
            seg[0] = 1'b0;
        end
    end

endmodule

/* verilog/settingsFormatter.sv */
`timescale 1ns/10ps
`include "display_macros.svh"

module settingsFormatter
    import displayPkg::*;
    import controlPkg::*;
(
    input  logic     O_CLK,
    input  logic     rstN,
    input  settingsT settings,
    input  logic     setValid,
    output frameT    frame,
    output logic     frameValid,
    input  logic     creditReturn
);

    // Wide enough to hold the full credit count
    localparam int CREDIT_W = $clog2(`FRAME_CREDITS + 1);

    fmtStateT            state;
    settingsT            pending;
    logic                dirty;
    logic [CREDIT_W-1:0] creditCount;
    logic                sendNow;

    // ************************************************************************
    // Settings to glyphs
    // ************************************************************************

    function automatic frameT buildFrame(input settingsT s);
        frameT f;
        f = blankFrame;

        // Speed x.yz on digits 2..0
        f.digit2.point = 1'b1;
        case (s.speed)
            3'd1, 3'd2: f.digit2.glyph = glyph0;
            3'd6:       f.digit2.glyph = glyph2;
            3'd7:       f.digit2.glyph = glyph3;
            default:    f.digit2.glyph = glyph1;
        endcase
        case (s.speed)
            3'd1, 3'd4: f.digit1.glyph = glyph2;
            3'd2, 3'd5: f.digit1.glyph = glyph5;
            default:    f.digit1.glyph = glyph0;
        endcase
        case (s.speed)
            3'd1, 3'd4: f.digit0.glyph = glyph5;
            default:    f.digit0.glyph = glyph0;
        endcase

        // Offset sign on digit 7
        // 0 and 4 both mean no offset
        case (s.freq)
            3'd1, 3'd2, 3'd3: f.digit7.glyph = glyphMinus;
            3'd5, 3'd6, 3'd7: f.digit7.glyph = glyphPlus;
            default:          f.digit7.glyph = glyphBlank;
        endcase
        // Magnitude on digit 6, minus side counts down
        case (s.freq)
            3'd1, 3'd7: f.digit6.glyph = glyph3;
            3'd2, 3'd6: f.digit6.glyph = glyph2;
            3'd3, 3'd5: f.digit6.glyph = glyph1;
            default:    f.digit6.glyph = glyph0;
        endcase
        return f;
    endfunction

    // ************************************************************************
    // Pending setting and credit flow
    // ************************************************************************

    // Only the newest unsent setting is kept
    always_ff @(posedge O_CLK) begin
        if (setValid) begin
            pending <= settings;
        end
        if (sendNow) begin
            frame <= buildFrame(pending);
        end
    end

    assign sendNow    = (state == fmtIdle) && dirty && (creditCount != '0);
    assign frameValid = (state == fmtSend);

    always_ff @(posedge O_CLK) begin
        if (!rstN) begin
            state       <= fmtIdle;
            dirty       <= 1'b0;
            creditCount <= CREDIT_W'(`FRAME_CREDITS);
        end
        else begin
            // Send and return together leave the count alone
            creditCount <= creditCount - CREDIT_W'(sendNow) + CREDIT_W'(creditReturn);
            // A fresh setting wins over the one going out
            if (setValid) begin
                dirty <= 1'b1;
            end
            else if (sendNow) begin
                dirty <= 1'b0;
            end
            unique case (state)
                fmtIdle: if (sendNow) state <= fmtSend;
                fmtSend: state <= fmtIdle;
            endcase
        end
    end

    // A frame on the link has taken a credit
    // so the count cannot be back at full
    assert property (@(posedge O_CLK) disable iff (!rstN)
        frameValid |-> int'(creditCount) < `FRAME_CREDITS);

    // The scan driver never returns more than it was given
    assert property (@(posedge O_CLK) disable iff (!rstN)
        int'(creditCount) <= `FRAME_CREDITS);

endmodule
